/* src/bdCore_macros.svh */
`ifndef BD_CORE_MACROS_SVH
`define BD_CORE_MACROS_SVH

// --------------------------------------------------
// FIFO sizing
// --------------------------------------------------
// Host commands waiting for the serializer
`define BD_DOWN_FIFO_DEPTH 16
// Tagged host words waiting for the host to drain
`define BD_UP_FIFO_DEPTH 16

// --------------------------------------------------
// Opcode map and core registers
// --------------------------------------------------
// Leaf opcodes at or above this are dropped
`define BD_NUM_LEAVES 34
`define BD_OPCODE_REG_BASE 64
`define BD_OPCODE_NOP_BASE 96
// Bit 0 pReset, bit 1 sReset
`define BD_REG_RESET_CTRL 31
`define BD_REG_UP_TAG 30
`define BD_DEFAULT_UP_TAG 8'hff

`endif

/* src/bdCorePkg.sv */
package bdCorePkg;

  // --------------------------------------------------
  // Host side
  // --------------------------------------------------
  // Pipe word, same width in and out
  typedef logic [31:0] hostWord_t;
  // Top five bits of a downstream word
  typedef logic [4:0]  routeField_t;
  // Selects leaf, register or nop
  typedef logic [6:0]  opCode_t;

  // --------------------------------------------------
  // Chip side
  // --------------------------------------------------
  // Leaf route in the low bits of each chip word
  typedef logic [5:0]  leafId_t;
  typedef logic [19:0] bdPayload_t;
  // One half of a payload per chip word
  typedef logic [9:0]  bdHalf_t;
  typedef logic [20:0] bdOutWord_t;
  typedef logic [33:0] bdInWord_t;

  // Core register access
  typedef logic [4:0]  regAddr_t;
  typedef logic [15:0] regData_t;
  typedef logic [7:0]  upTag_t;

  // Downstream command held in the FIFO
  typedef struct packed {
    leafId_t    leaf;
    bdPayload_t payload;
  } bdDownCmd_t;

  // Decoded register write
  typedef struct packed {
    regAddr_t addr;
    regData_t data;
  } regWrite_t;

endpackage

/* src/hostWordDecoder.sv */
`include "bdCore_macros.svh"

module hostWordDecoder (
  input  logic                  okClk,
  input  logic                  arstN,
  input  logic                  pipeInWrite,
  input  bdCorePkg::hostWord_t  pipeInData,
  output logic                  cmdValid,
  output bdCorePkg::bdDownCmd_t cmd,
  output logic                  regWriteValid,
  output bdCorePkg::regWrite_t  regWrite
);
  import bdCorePkg::*;

  // Fields of the incoming word
  routeField_t route;
  opCode_t     opCode;
  bdPayload_t  payload;

  // Opcode class
  logic routeOk;
  logic isLeaf;
  logic isNop;
  logic isReg;

  // Words that survive decoding
  logic acceptCmd;
  logic acceptReg;

  // --------------------------------------------------
  // Field split and classification
  // --------------------------------------------------
  assign route   = pipeInData[31:27];
  assign opCode  = pipeInData[26:20];
  assign payload = pipeInData[19:0];

  // Only route zero belongs to this core
  assign routeOk = (route == '0);
  // Valid leaves sit at the bottom of the leaf range
  assign isLeaf  = (opCode < opCode_t'(`BD_NUM_LEAVES));
  assign isNop   = (opCode >= opCode_t'(`BD_OPCODE_NOP_BASE));
  assign isReg   = (opCode >= opCode_t'(`BD_OPCODE_REG_BASE)) && !isNop;

  assign acceptCmd = pipeInWrite && routeOk && isLeaf;
  assign acceptReg = pipeInWrite && routeOk && isReg;

  // --------------------------------------------------
  // Output registers
  // --------------------------------------------------
  // One-cycle strobes, one cycle after the host strobe
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      cmdValid      <= 1'b0;
      regWriteValid <= 1'b0;
    end else begin
      cmdValid      <= acceptCmd;
      regWriteValid <= acceptReg;
    end
  end

  // Payload side, loaded only on an accepted word
  always_ff @(posedge okClk) begin
    if (acceptCmd) begin
      cmd.leaf    <= leafId_t'(opCode);
      cmd.payload <= payload;
    end
    if (acceptReg) begin
      // Register number is the offset into the register opcodes
      regWrite.addr <= regAddr_t'(opCode - opCode_t'(`BD_OPCODE_REG_BASE));
      regWrite.data <= payload[15:0];
    end
  end

endmodule

/* src/confRegFile.sv */
`include "bdCore_macros.svh"

module confRegFile (
  input  logic                 okClk,
  input  logic                 arstN,
  input  logic                 regWriteValid,
  input  bdCorePkg::regWrite_t regWrite,
  output logic                 pReset,
  output logic                 sReset,
  output bdCorePkg::upTag_t    upTag
);
  import bdCorePkg::*;

  // Address match per register
  logic hitResetCtrl;
  logic hitUpTag;

  assign hitResetCtrl = regWriteValid && (regWrite.addr == regAddr_t'(`BD_REG_RESET_CTRL));
  assign hitUpTag     = regWriteValid && (regWrite.addr == regAddr_t'(`BD_REG_UP_TAG));

  // --------------------------------------------------
  // Reset-control register
  // --------------------------------------------------
  // Chip held in reset until the host clears it
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      pReset <= 1'b1;
      sReset <= 1'b1;
    end else if (hitResetCtrl) begin
      pReset <= regWrite.data[0];
      sReset <= regWrite.data[1];
    end
  end

  // --------------------------------------------------
  // Upstream tag register
  // --------------------------------------------------
  // Low byte of the write data, upper bits ignored
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      upTag <= `BD_DEFAULT_UP_TAG;
    end else if (hitUpTag) begin
      upTag <= regWrite.data[7:0];
    end
  end

  // Any other address falls through untouched

endmodule

/* src/wordFifo.sv */
module wordFifo #(
  parameter int WordWidth = 32,
  parameter int Depth     = 16
) (
  input  logic                         okClk,
  input  logic                         arstN,
  input  logic                         push,
  input  logic [WordWidth-1:0]         pushData,
  input  logic                         pop,
  output logic [WordWidth-1:0]         popData,
  output logic                         notEmpty,
  output logic                         full,
  output logic [$clog2(Depth+1)-1:0]   freeCount
);

  localparam int PtrWidth   = $clog2(Depth);
  localparam int CountWidth = $clog2(Depth+1);

  // Storage
  logic [WordWidth-1:0] mem [Depth];

  // Pointers and occupancy
  logic [PtrWidth-1:0]   wrPtr;
  logic [PtrWidth-1:0]   rdPtr;
  logic [CountWidth-1:0] count;

  // Qualified requests, full push and empty pop dropped
  logic doPush;
  logic doPop;

  assign doPush = push && !full;
  assign doPop  = pop && notEmpty;

  // Status
  assign notEmpty  = (count != '0);
  assign full      = (count == CountWidth'(Depth));
  assign freeCount = CountWidth'(Depth) - count;

  // Head word shown without a pop
  assign popData = mem[rdPtr];

  always_ff @(posedge okClk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  // Pointers wrap explicitly, depth need not be a power of two
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* src/bdDownSerializer.sv */
module bdDownSerializer (
  input  logic                  okClk,
  input  logic                  arstN,
  input  logic                  pReset,
  input  logic                  cmdValid,
  input  logic                  fifoFull,
  input  bdCorePkg::bdDownCmd_t cmdHead,
  input  logic                  cmdAvail,
  output logic                  cmdPop,
  output logic                  bdOutValid,
  input  logic                  bdOutReady,
  output bdCorePkg::bdOutWord_t bdOutData,
  output logic                  downOverflow
);
  import bdCorePkg::*;

  typedef enum logic [1:0] {IDLE, LOW_HALF, HIGH_HALF} serState_t;

  serState_t  state;
  serState_t  stateNext;
  bdDownCmd_t curCmd;
  bdHalf_t    curHalf;
  logic       loadCmd;

  // Take the FIFO head only when idle and the chip is out of reset
  assign loadCmd = (state == IDLE) && !pReset && cmdAvail;
  assign cmdPop  = loadCmd;

  // --------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------
  always_comb begin
    stateNext = state;
    case (state)
      IDLE:      if (loadCmd) stateNext = LOW_HALF;
      LOW_HALF:  if (bdOutReady) stateNext = HIGH_HALF;
      HIGH_HALF: if (bdOutReady) stateNext = IDLE;
      default:   stateNext = IDLE;
    endcase
  end

  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  // Command held for both halves
  always_ff @(posedge okClk) begin
    if (loadCmd) begin
      curCmd <= cmdHead;
    end
  end

  // Chip word, stable until accepted since both sources are flops
  assign curHalf    = (state == HIGH_HALF) ? curCmd.payload[19:10] : curCmd.payload[9:0];
  assign bdOutValid = (state != IDLE);
  assign bdOutData  = {5'b0, curHalf, curCmd.leaf};

  // Sticky, a command arriving at a full FIFO is lost
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      downOverflow <= 1'b0;
    end else if (cmdValid && fifoFull) begin
      downOverflow <= 1'b1;
    end
  end

endmodule

/* src/bdUpPacker.sv */
`include "bdCore_macros.svh"

module bdUpPacker (
  input  logic                                   okClk,
  input  logic                                   arstN,
  input  logic                                   sReset,
  input  bdCorePkg::upTag_t                      upTag,
  input  logic                                   bdInValidN,
  input  bdCorePkg::bdInWord_t                   bdInData,
  output logic                                   bdInReady,
  input  logic [$clog2(`BD_UP_FIFO_DEPTH+1)-1:0] upFree,
  output logic                                   upPush,
  output bdCorePkg::hostWord_t                   upWord
);
  import bdCorePkg::*;

  localparam int FreeWidth = $clog2(`BD_UP_FIFO_DEPTH+1);

  typedef enum logic [1:0] {IDLE, WORD_A, WORD_B} packState_t;

  packState_t state;
  bdInWord_t  inWord;
  upTag_t     tagReg;
  logic       capture;

  // Both host words must fit before a chip word is taken
  assign bdInReady = (state == IDLE) && !sReset && (upFree >= FreeWidth'(2));
  // Chip valid is active low
  assign capture   = bdInReady && !bdInValidN;

  // --------------------------------------------------
  // Sequencer, one host word per cycle
  // --------------------------------------------------
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (capture) state <= WORD_A;
        WORD_A:  state <= WORD_B;
        default: state <= IDLE;
      endcase
    end
  end

  // Tag sampled with the data so a pair never mixes tags
  always_ff @(posedge okClk) begin
    if (capture) begin
      inWord <= bdInData;
      tagReg <= upTag;
    end
  end

  always_comb begin
    upPush = 1'b0;
    upWord = '0;
    case (state)
      // Low 24 bits of the chip word
      WORD_A: begin
        upPush = 1'b1;
        upWord = {tagReg, inWord[23:0]};
      end
      // Remaining 10 bits, zero padded
      WORD_B: begin
        upPush = 1'b1;
        upWord = {tagReg, 14'b0, inWord[33:24]};
      end
      default: ;
    endcase
  end

endmodule

/* src/bdCore.sv */
`include "bdCore_macros.svh"

module bdCore (
  input  logic                  okClk,
  input  logic                  arstN,
  // Host pipes
  input  logic                  pipeInWrite,
  input  bdCorePkg::hostWord_t  pipeInData,
  input  logic                  pipeOutRead,
  output bdCorePkg::hostWord_t  pipeOutData,
  output logic                  pipeOutValid,
  // Chip downstream link
  output logic                  bdOutValid,
  input  logic                  bdOutReady,
  output bdCorePkg::bdOutWord_t bdOutData,
  // Chip upstream link
  input  logic                  bdInValidN,
  output logic                  bdInReady,
  input  bdCorePkg::bdInWord_t  bdInData,
  // Chip resets and status
  output logic                  pReset,
  output logic                  sReset,
  output logic                  downOverflow
);
  import bdCorePkg::*;

  // Decoder outputs
  logic       cmdValid;
  bdDownCmd_t cmd;
  logic       regWriteValid;
  regWrite_t  regWrite;
  upTag_t     upTag;

  // Downstream FIFO to serializer
  bdDownCmd_t cmdHead;
  logic       cmdAvail;
  logic       cmdPop;
  logic       downFull;

  // Packer to upstream FIFO
  logic                                   upPush;
  hostWord_t                              upWord;
  logic [$clog2(`BD_UP_FIFO_DEPTH+1)-1:0] upFree;

  // --------------------------------------------------
  // Downstream path
  // --------------------------------------------------
  hostWordDecoder decoder (
    .okClk, .arstN, .pipeInWrite, .pipeInData,
    .cmdValid, .cmd, .regWriteValid, .regWrite
  );

  confRegFile regFile (
    .okClk, .arstN, .regWriteValid, .regWrite,
    .pReset, .sReset, .upTag
  );

  wordFifo #(.WordWidth($bits(bdDownCmd_t)), .Depth(`BD_DOWN_FIFO_DEPTH)) downFifo (
    .okClk, .arstN,
    .push(cmdValid), .pushData(cmd),
    .pop(cmdPop), .popData(cmdHead),
    .notEmpty(cmdAvail), .full(downFull), .freeCount()
  );

  bdDownSerializer serializer (
    .okClk, .arstN, .pReset, .cmdValid,
    .fifoFull(downFull), .cmdHead, .cmdAvail, .cmdPop,
    .bdOutValid, .bdOutReady, .bdOutData, .downOverflow
  );

  // --------------------------------------------------
  // Upstream path
  // --------------------------------------------------
  bdUpPacker packer (
    .okClk, .arstN, .sReset, .upTag,
    .bdInValidN, .bdInData, .bdInReady,
    .upFree, .upPush, .upWord
  );

  // Host drains straight from the head
  wordFifo #(.WordWidth($bits(hostWord_t)), .Depth(`BD_UP_FIFO_DEPTH)) upFifo (
    .okClk, .arstN,
    .push(upPush), .pushData(upWord),
    .pop(pipeOutRead), .popData(pipeOutData),
    .notEmpty(pipeOutValid), .full(), .freeCount(upFree)
  );

endmodule

/* dv/tbClockGen.sv */
module tbClockGen (
  output logic okClk,
  output logic arstN
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HalfPeriod  = 5;
  localparam int ResetCycles = 5;

  // 10 ns period
  initial begin
    okClk = 1'b0;
    forever #HalfPeriod okClk = ~okClk;
  end

  // Released just after an edge
  initial begin
    arstN = 1'b0;
    repeat (ResetCycles) @(posedge okClk);
    #1;
    arstN = 1'b1;
  end

endmodule

/* dv/bdCoreTb.sv */
`include "bdCore_macros.svh"

module bdCoreTb;
  timeunit 1ns;
  timeprecision 100ps;
  import bdCorePkg::*;

  // Longest run is well under a thousand cycles
  localparam int MaxCycles = 4000;
  localparam logic [31:0] Seed = 32'ha39ae548;

  logic       okClk;
  logic       arstN;
  logic       pipeInWrite;
  hostWord_t  pipeInData;
  logic       pipeOutRead;
  hostWord_t  pipeOutData;
  logic       pipeOutValid;
  logic       bdOutValid;
  logic       bdOutReady;
  bdOutWord_t bdOutData;
  logic       bdInValidN;
  logic       bdInReady;
  bdInWord_t  bdInData;
  logic       pReset;
  logic       sReset;
  logic       downOverflow;

  // Expected chip words and host words in arrival order
  bdOutWord_t downQ[$];
  hostWord_t  upQ[$];
  upTag_t     expTag;

  // Separate streams for host words and bus noise
  logic [31:0] mainSeed;
  logic [31:0] busSeed;
  // 0 ready low, 1 ready high, 2 random
  int          readyMode;
  logic        chipOn;
  int          cycleCount;

  tbClockGen clockGen (.okClk, .arstN);

  bdCore dut (.*);

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp)
      else failRun($sformatf("mismatch at %0t ns: %s expected %0h got %0h",
                             $time, name, exp, got));
  endtask

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic nextBits(inout logic [31:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits  = {bits[30:0], state[0]};
      state = lfsrStep(state);
    end
  endtask

  function automatic hostWord_t makeWord(input int route, input int op, input bdPayload_t pl);
    return {routeField_t'(route), opCode_t'(op), pl};
  endfunction

  function automatic hostWord_t regWord(input int addr, input regData_t data);
    return makeWord(0, `BD_OPCODE_REG_BASE + addr, {4'b0, data});
  endfunction

  // Five zero bits, half, then leaf in the low bits
  function automatic bdOutWord_t chipWord(input leafId_t leaf, input bdHalf_t half);
    return {5'b0, half, leaf};
  endfunction

  task automatic hostWrite(input hostWord_t w);
    pipeInData  = w;
    pipeInWrite = 1'b1;
    @(posedge okClk);
    #1;
    pipeInWrite = 1'b0;
  endtask

  // Route zero leaf words below the leaf count reach the chip low half first
  task automatic sendWord(input hostWord_t w);
    if (w[31:27] == '0 && w[26:20] < `BD_NUM_LEAVES) begin
      downQ.push_back(chipWord(w[25:20], w[9:0]));
      downQ.push_back(chipWord(w[25:20], w[19:10]));
    end
    hostWrite(w);
  endtask

  // Mix of leaves, dropped words and ignored register writes
  task automatic randomWords(input int count, input int gap);
    logic [31:0] kind;
    logic [31:0] r;
    logic [31:0] pl;
    hostWord_t   w;
    for (int i = 0; i < count; i++) begin
      nextBits(mainSeed, 3, kind);
      nextBits(mainSeed, 7, r);
      nextBits(mainSeed, 20, pl);
      case (kind[2:0])
        3'd4:    w = makeWord(0, `BD_NUM_LEAVES + r % (64 - `BD_NUM_LEAVES), pl[19:0]);
        3'd5:    w = makeWord(1 + r % 31, r, pl[19:0]);
        3'd6:    w = makeWord(0, `BD_OPCODE_NOP_BASE + r % 32, pl[19:0]);
        // Register addresses 0 to 29 only
        3'd7:    w = makeWord(0, `BD_OPCODE_REG_BASE + r % 30, pl[19:0]);
        default: w = makeWord(0, r % `BD_NUM_LEAVES, pl[19:0]);
      endcase
      sendWord(w);
      repeat (gap) @(posedge okClk);
      #1;
    end
  endtask

  task automatic waitDrained();
    while (downQ.size() != 0 || upQ.size() != 0) begin
      @(posedge okClk);
      #1;
    end
  endtask

  // --------------------------------------------------
  // Checkers
  // --------------------------------------------------
  // Negedge sample sees the values the DUT takes at the next edge
  always @(negedge okClk) begin
    if (arstN) begin
      if (bdOutValid && bdOutReady) begin
        assert (downQ.size() != 0) else failRun("chip transfer with no command pending");
        checkValue("bdOutData", bdOutData, downQ.pop_front());
      end
      // Chip word taken with the tag in effect at capture
      if (bdInReady && !bdInValidN) begin
        upQ.push_back({expTag, bdInData[23:0]});
        upQ.push_back({expTag, 14'b0, bdInData[33:24]});
      end
      if (pipeOutValid && pipeOutRead) begin
        assert (upQ.size() != 0) else failRun("host read a word that was never sent");
        checkValue("pipeOutData", pipeOutData, upQ.pop_front());
      end
    end
  end

  assert property (@(posedge okClk) disable iff (!arstN)
                   (bdOutValid && !bdOutReady) |=> (bdOutValid && $stable(bdOutData)))
    else failRun("chip word changed or was withdrawn while stalled");

  assert property (@(posedge okClk) disable iff (!arstN) pReset |-> !bdOutValid)
    else failRun("bdOutValid raised while pReset was high");

  assert property (@(posedge okClk) disable iff (!arstN) downOverflow |=> downOverflow)
    else failRun("downOverflow cleared after it was set");

  always @(posedge okClk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= MaxCycles) begin
      failRun($sformatf("timeout, run still busy after %0d cycles", cycleCount));
    end
  end

  // --------------------------------------------------
  // Bus noise for ready, read strobes and chip words
  // --------------------------------------------------
  always @(posedge okClk) begin
    logic [31:0] bits;
    int          mode;
    logic        chipActive;
    // Mode changes take effect one cycle later
    mode       = readyMode;
    chipActive = chipOn;
    #1;
    nextBits(busSeed, 2, bits);
    // Random mode is ready three cycles in four
    bdOutReady = (mode == 2) ? |bits[1:0] : (mode == 1);
    nextBits(busSeed, 1, bits);
    pipeOutRead = bits[0];
    if (chipActive) begin
      nextBits(busSeed, 1, bits);
      bdInValidN = bits[0];
      nextBits(busSeed, 32, bits);
      bdInData[31:0] = bits;
      nextBits(busSeed, 2, bits);
      bdInData[33:32] = bits[1:0];
    end else begin
      bdInValidN = 1'b1;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] bits;
    pipeInWrite = 1'b0;
    pipeInData  = '0;
    pipeOutRead = 1'b0;
    bdOutReady  = 1'b0;
    bdInValidN  = 1'b1;
    bdInData    = '0;
    mainSeed    = Seed;
    busSeed     = Seed;
    readyMode   = 0;
    chipOn      = 1'b0;
    cycleCount  = 0;
    expTag      = `BD_DEFAULT_UP_TAG;
    wait (arstN === 1'b1);
    @(posedge okClk);
    #1;

    // Reset values
    checkValue("pReset", pReset, 1);
    checkValue("sReset", sReset, 1);
    checkValue("bdOutValid", bdOutValid, 0);
    checkValue("bdInReady", bdInReady, 0);
    checkValue("pipeOutValid", pipeOutValid, 0);
    checkValue("downOverflow", downOverflow, 0);

    // Leaf held in the FIFO until pReset drops
    readyMode = 1;
    sendWord(makeWord(0, 3, 20'h5a5a5));
    repeat (4) @(posedge okClk);
    #1;
    sendWord(regWord(`BD_REG_RESET_CTRL, 16'h0000));
    checkValue("pReset", pReset, 1);
    checkValue("sReset", sReset, 1);
    @(posedge okClk);
    #1;
    checkValue("pReset", pReset, 0);
    checkValue("sReset", sReset, 0);

    // Format, order and drops with the chip always ready
    randomWords(30, 3);
    waitDrained();

    // Back-pressure both ways and upstream words under the default tag
    readyMode = 2;
    chipOn    = 1'b1;
    randomWords(40, 5);
    chipOn = 1'b0;
    waitDrained();
    checkValue("pReset", pReset, 0);
    checkValue("sReset", sReset, 0);

    // New tag written while upstream is idle
    sendWord(regWord(`BD_REG_UP_TAG, 16'h005a));
    expTag = 8'h5a;
    repeat (3) @(posedge okClk);
    #1;
    chipOn = 1'b1;
    repeat (150) @(posedge okClk);
    #1;
    chipOn = 1'b0;
    waitDrained();

    // Overflow after one command in the serializer and sixteen queued
    readyMode = 0;
    for (int i = 0; i < 17; i++) begin
      nextBits(mainSeed, 20, bits);
      sendWord(makeWord(0, i, bits[19:0]));
    end
    repeat (2) @(posedge okClk);
    #1;
    checkValue("downOverflow", downOverflow, 0);
    // Lost word adds no expected chip words
    hostWrite(makeWord(0, 1, 20'h12345));
    checkValue("downOverflow", downOverflow, 0);
    @(posedge okClk);
    #1;
    checkValue("downOverflow", downOverflow, 1);
    readyMode = 1;
    waitDrained();
    checkValue("downOverflow", downOverflow, 1);

    $display("No errors");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+src
src/bdCorePkg.sv
src/hostWordDecoder.sv
src/confRegFile.sv
src/wordFifo.sv
src/bdDownSerializer.sv
src/bdUpPacker.sv
src/bdCore.sv
dv/tbClockGen.sv
dv/bdCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= bdCoreTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o sim
	@out="$$(./$(OBJ_DIR)/sim)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
